// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_pipe_top
FILELIST  = pipe_ctrl.f

SRCS = $(wildcard verilog/*.sv) $(wildcard sim/*.sv)
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// File: pipe_ctrl.f
verilog/pipe_pkg.sv
verilog/stall_ctrl.sv
verilog/pc_gen.sv
verilog/stage_reg.sv
verilog/retire_unit.sv
verilog/pipe_top.sv
sim/tb_pipe_top.sv

// File: sim/tb_pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pipe_top
    import pipe_pkg::*;
;

    localparam addr_t RESET_PC = 32'hBFC0_0000;

    logic    clk = 1'b0;
    logic    rst_n;
    logic    stallreq_id;
    logic    stallreq_ex;
    logic    stallreq_mem;
    excode_t excode;
    addr_t   fetch_pc;
    logic    flush;
    addr_t   new_pc;
    logic    retire_valid;
    addr_t   retire_pc;
    count_t  retire_count;

    // reference model state, slot 0 is if/id
    addr_t      m_pc;
    logic [3:0] m_valid;
    addr_t      m_spc [0:3];
    count_t     m_count;
    addr_t      m_epc;

    logic [31:0] seed = 32'h99076c1d;
    excode_t     code_table [0:15];
    integer      err_count = 0;
    integer      check_count = 0;
    integer      test_count = 0;
    integer      failed_tests = 0;
    integer      test_start_errs = 0;

    pipe_top #(
        .RESET_PC (RESET_PC)
    ) dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .stallreq_id  (stallreq_id),
        .stallreq_ex  (stallreq_ex),
        .stallreq_mem (stallreq_mem),
        .excode       (excode),
        .fetch_pc     (fetch_pc),
        .flush        (flush),
        .new_pc       (new_pc),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_count (retire_count)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // refill codes, eret back to epc, everything else general
    function automatic addr_t expected_vector(input excode_t code, input addr_t ret_pc);
        if (code == EXC_TLBRL_CODE || code == EXC_TLBRL_DATA || code == EXC_TLBRS)
            return REFILL_VECTOR;
        else if (code == EXC_ERET)
            return ret_pc;
        return GENERAL_VECTOR;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp)
        begin
            $display("ERROR at %0t ns: %s got %h expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic finish_test(input string name);
        test_count++;
        if (err_count != test_start_errs)
            failed_tests++;
        $display("test %0d %s: %s (%0d errors)", test_count, name,
                 (err_count == test_start_errs) ? "ok" : "FAILED", err_count - test_start_errs);
        test_start_errs = err_count;
    endtask

    // one cycle: drive after the edge, compare before the next one, advance the model
    task automatic step(input logic req_id, input logic req_ex, input logic req_mem,
                        input excode_t code);
        stall_t st;
        logic   fl;
        addr_t  npc;
        integer k;
        @(posedge clk);
        #1;
        // reset drops with the first stimulus
        rst_n        = 1'b1;
        stallreq_id  = req_id;
        stallreq_ex  = req_ex;
        stallreq_mem = req_mem;
        excode       = code;
        #5;
        fl  = (code != '0);
        npc = fl ? expected_vector(code, m_epc) : '0;
        if (fl)
            st = STALL_NONE;
        else if (req_mem)
            st = STALL_MEM;
        else if (req_ex)
            st = STALL_EX;
        else if (req_id)
            st = STALL_ID;
        else
            st = STALL_NONE;
        check("fetch_pc", fetch_pc, m_pc);
        check("flush", {31'b0, flush}, {31'b0, fl});
        check("new_pc", new_pc, npc);
        check("retire_valid", {31'b0, retire_valid}, {31'b0, m_valid[3]});
        if (m_valid[3])
            check("retire_pc", retire_pc, m_spc[3]);
        check("retire_count", retire_count, m_count);
        if (m_valid[3])
        begin
            m_count = m_count + 32'd1;
            m_epc   = m_spc[3];
        end
        // deepest slot first so each reads its predecessor's old value
        for (k = 3; k >= 0; k--)
        begin
            if (fl || (st[k+1] && !st[k+2]))
                m_valid[k] = 1'b0;
            else if (!st[k+1] && k == 0)
            begin
                m_valid[k] = 1'b1;
                m_spc[k]   = m_pc;
            end
            else if (!st[k+1])
            begin
                m_valid[k] = m_valid[k-1];
                m_spc[k]   = m_spc[k-1];
            end
        end
        if (fl)
            m_pc = npc;
        else if (!st[0])
            m_pc = m_pc + 32'd4;
    endtask

    task automatic rand_step(input logic allow_exc);
        logic [31:0] r;
        excode_t     code;
        r    = next_rand();
        code = '0;
        if (allow_exc && r[3:0] == 4'd0)
            code = code_table[r[7:4]];
        else if (allow_exc && r[3:0] == 4'd1 && r[8])
            code = {20'h0, 4'h1, r[15:8]};
        step(r[28] & r[29], r[26] & r[27], r[24] & r[25], code);
    endtask

    task automatic reset_and_fill();
        integer n;
        integer i;
        rst_n = 1'b0;
        m_pc = RESET_PC;
        m_valid = '0;
        m_count = '0;
        m_epc = '0;
        for (i = 0; i < 4; i++)
            m_spc[i] = '0;
        // the first step supplies the sixteenth reset edge
        repeat (15) @(posedge clk);
        step(1'b0, 1'b0, 1'b0, '0);
        check("fetch_pc", fetch_pc, RESET_PC);
        check("retire_valid", {31'b0, retire_valid}, 32'd0);
        check("flush", {31'b0, flush}, 32'd0);
        n = 0;
        while (!retire_valid && n < 20)
        begin
            step(1'b0, 1'b0, 1'b0, '0);
            n++;
        end
        if (!retire_valid)
        begin
            $display("timeout: nothing retired within 20 cycles after reset release");
            err_count++;
        end
        else
        begin
            check("fill latency", n, 32'd4);
            for (i = 0; i < 8; i++)
            begin
                check("retire_pc", retire_pc, RESET_PC + 32'd4 * i);
                step(1'b0, 1'b0, 1'b0, '0);
            end
        end
        finish_test("reset and fill");
    endtask

    task automatic exception_vectors();
        integer i;
        integer n;
        addr_t  vec;
        for (i = 0; i < 15; i++)
        begin
            repeat (6) step(1'b0, 1'b0, 1'b0, '0);
            vec = expected_vector(code_table[i], m_epc);
            step(1'b0, 1'b0, 1'b0, code_table[i]);
            check("flush", {31'b0, flush}, 32'd1);
            check("new_pc", new_pc, vec);
            step(1'b0, 1'b0, 1'b0, '0);
            check("fetch_pc", fetch_pc, vec);
            // the first token to retire must be the vector itself
            n = 0;
            while (!retire_valid && n < 16)
            begin
                step(1'b0, 1'b0, 1'b0, '0);
                n++;
            end
            if (!retire_valid)
            begin
                $display("timeout: nothing retired after exception code %h", code_table[i]);
                err_count++;
            end
            else
                check("retire_pc", retire_pc, vec);
        end
        finish_test("exception vectors");
    endtask

    task automatic eret_return();
        integer t;
        integer n;
        addr_t  ret;
        for (t = 0; t < 4; t++)
        begin
            n = 0;
            rand_step(1'b0);
            while (!retire_valid && n < 64)
            begin
                rand_step(1'b0);
                n++;
            end
            if (!retire_valid)
            begin
                $display("timeout: no retirement before eret trial %0d", t);
                err_count++;
            end
            ret = m_epc;
            step(1'b0, 1'b0, 1'b0, EXC_ERET);
            check("new_pc", new_pc, ret);
            step(1'b0, 1'b0, 1'b0, '0);
            check("fetch_pc", fetch_pc, ret);
        end
        finish_test("eret return");
    endtask

    initial
    begin
        stallreq_id  = 1'b0;
        stallreq_ex  = 1'b0;
        stallreq_mem = 1'b0;
        excode       = '0;
        rst_n        = 1'b0;
        code_table = '{EXC_INT, EXC_SYSCALL, EXC_BREAK, EXC_RI, EXC_OV, EXC_TRAP,
                       EXC_ADEL, EXC_ADES, EXC_TLBRL_CODE, EXC_TLBRL_DATA, EXC_TLBRS,
                       EXC_TLBIL_CODE, EXC_TLBIL_DATA, EXC_TLBIS, EXC_TLBM, EXC_ERET};

        reset_and_fill();

        repeat (1000) rand_step(1'b0);
        finish_test("random stalls");

        exception_vectors();
        eret_return();

        // all requests high together with an exception
        step(1'b1, 1'b1, 1'b1, EXC_SYSCALL);
        check("flush", {31'b0, flush}, 32'd1);
        step(1'b0, 1'b0, 1'b0, '0);
        check("fetch_pc", fetch_pc, GENERAL_VECTOR);
        repeat (2000) rand_step(1'b1);
        finish_test("mixed exceptions and stalls");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, failed_tests, check_count, err_count);
        if (err_count == 0)
        begin
            $display("All tests passed");
        end
        else
        begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

module pc_gen
    import pipe_pkg::*;
#(
    parameter addr_t RESET_PC = 32'hBFC0_0000
)
(
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire stall_t stall,
    input  wire logic   flush,
    input  wire addr_t  new_pc,
    output addr_t       pc
);

    addr_t pc_q;
    addr_t pc_next;
    logic  hold;

    // only the pc bit of the stall vector matters here
    assign hold = stall[0];

    always_comb
    begin
        if (flush)
        begin
            // redirect wins over a hold
            pc_next = new_pc;
        end
        else if (hold)
        begin
            pc_next = pc_q;
        end
        else
        begin
            pc_next = pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pc_q <= RESET_PC;
        end
        else
        begin
            pc_q <= pc_next;
        end
    end

    assign pc = pc_q;

endmodule

`default_nettype wire

// File: verilog/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // instruction address / pc
    typedef logic [31:0] addr_t;
    // exception code reported at MEM, zero means none
    typedef logic [31:0] excode_t;
    // bit 0 pc, 1 if, 2 id, 3 ex, 4 mem, 5 wb
    typedef logic [5:0]  stall_t;
    typedef logic [31:0] count_t;

    // exception codes
    localparam excode_t EXC_INT        = 32'h0000_0001;
    localparam excode_t EXC_SYSCALL    = 32'h0000_0008;
    localparam excode_t EXC_BREAK      = 32'h0000_0009;
    localparam excode_t EXC_RI         = 32'h0000_000a;
    localparam excode_t EXC_OV         = 32'h0000_000c;
    localparam excode_t EXC_TRAP       = 32'h0000_000d;
    localparam excode_t EXC_ERET       = 32'h0000_000e;
    // address errors
    localparam excode_t EXC_ADEL       = 32'h0000_0004;
    localparam excode_t EXC_ADES       = 32'h0000_0005;
    // tlb refill, go to the refill vector
    localparam excode_t EXC_TLBRL_CODE = 32'h0000_0011;
    localparam excode_t EXC_TLBRL_DATA = 32'h0000_0012;
    localparam excode_t EXC_TLBRS      = 32'h0000_0013;
    // tlb invalid and modify
    localparam excode_t EXC_TLBIL_CODE = 32'h0000_0021;
    localparam excode_t EXC_TLBIL_DATA = 32'h0000_0022;
    localparam excode_t EXC_TLBIS      = 32'h0000_0023;
    localparam excode_t EXC_TLBM       = 32'h0000_0024;

    // exception vectors
    localparam addr_t GENERAL_VECTOR = 32'hBFC0_0380;
    localparam addr_t REFILL_VECTOR  = 32'hBFC0_0200;

    // stall patterns, a set bit holds that stage
    localparam stall_t STALL_MEM  = 6'b011111;
    localparam stall_t STALL_EX   = 6'b001111;
    localparam stall_t STALL_ID   = 6'b000111;
    localparam stall_t STALL_NONE = 6'b000000;

endpackage

`default_nettype wire

// File: verilog/pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_top
    import pipe_pkg::*;
#(
    parameter addr_t RESET_PC = 32'hBFC0_0000
)
(
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    stallreq_id,
    input  wire logic    stallreq_ex,
    input  wire logic    stallreq_mem,
    input  wire excode_t excode,
    output addr_t        fetch_pc,
    output logic         flush,
    output addr_t        new_pc,
    output logic         retire_valid,
    output addr_t        retire_pc,
    output count_t       retire_count
);

    stall_t     stall;
    addr_t      epc;
    // token chain, entry 0 is the fetch side
    logic [4:0] stage_valid;
    addr_t      stage_pc [0:4];

    stall_ctrl u_stall_ctrl (
        .stallreq_id  (stallreq_id),
        .stallreq_ex  (stallreq_ex),
        .stallreq_mem (stallreq_mem),
        .excode       (excode),
        .epc          (epc),
        .stall        (stall),
        .flush        (flush),
        .new_pc       (new_pc)
    );

    pc_gen #(
        .RESET_PC (RESET_PC)
    ) u_pc_gen (
        .clk    (clk),
        .rst_n  (rst_n),
        .stall  (stall),
        .flush  (flush),
        .new_pc (new_pc),
        .pc     (fetch_pc)
    );

    // every fetch slot carries an instruction
    assign stage_valid[0] = 1'b1;
    assign stage_pc[0]    = fetch_pc;

    // if/id, id/ex, ex/mem, mem/wb
    for (genvar k = 0; k < 4; k++)
    begin : g_stage
        stage_reg u_stage_reg (
            .clk       (clk),
            .rst_n     (rst_n),
            .hold_self (stall[k+1]),
            .hold_next (stall[k+2]),
            .flush     (flush),
            .valid_in  (stage_valid[k]),
            .pc_in     (stage_pc[k]),
            .valid_out (stage_valid[k+1]),
            .pc_out    (stage_pc[k+1])
        );
    end

    retire_unit u_retire_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_in     (stage_valid[4]),
        .pc_in        (stage_pc[4]),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_count (retire_count),
        .epc          (epc)
    );

endmodule

`default_nettype wire

// File: verilog/retire_unit.sv
`timescale 1ns/1ps
`default_nettype none

module retire_unit
    import pipe_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  valid_in,
    input  wire addr_t pc_in,
    output logic       retire_valid,
    output addr_t      retire_pc,
    output count_t     retire_count,
    output addr_t      epc
);

    count_t count_q;
    addr_t  epc_q;

    // wb never stalls, the last register drains straight out
    assign retire_valid = valid_in;
    assign retire_pc    = pc_in;

    // retired instruction count
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            count_q <= '0;
        end
        else if (retire_valid)
        begin
            count_q <= count_q + 32'd1;
        end
    end

    // return address for eret
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            epc_q <= '0;
        end
        else if (retire_valid)
        begin
            epc_q <= retire_pc;
        end
    end

    assign retire_count = count_q;
    assign epc          = epc_q;

endmodule

`default_nettype wire

// File: verilog/stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module stage_reg
    import pipe_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  hold_self,
    input  wire logic  hold_next,
    input  wire logic  flush,
    input  wire logic  valid_in,
    input  wire addr_t pc_in,
    output logic       valid_out,
    output addr_t      pc_out
);

    logic  valid_q;
    addr_t pc_q;
    logic  bubble;

    // this stage stops but the next one moves on
    assign bubble = hold_self && !hold_next;

    // token valid bit
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            valid_q <= 1'b0;
        end
        else if (flush || bubble)
        begin
            valid_q <= 1'b0;
        end
        else if (!hold_self)
        begin
            valid_q <= valid_in;
        end
    end

    // pc payload, kept on a bubble or a hold
    always_ff @(posedge clk)
    begin
        if (!flush && !hold_self)
        begin
            pc_q <= pc_in;
        end
    end

    assign valid_out = valid_q;
    assign pc_out    = pc_q;

endmodule

`default_nettype wire

// File: verilog/stall_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module stall_ctrl
    import pipe_pkg::*;
(
    input  wire logic    stallreq_id,
    input  wire logic    stallreq_ex,
    input  wire logic    stallreq_mem,
    input  wire excode_t excode,
    input  wire addr_t   epc,
    output stall_t       stall,
    output logic         flush,
    output addr_t        new_pc
);

    logic  exc_taken;
    addr_t exc_vector;

    assign exc_taken = (excode != '0);

    // target address for each exception code
    always_comb
    begin
        case (excode)
            EXC_TLBRL_CODE,
            EXC_TLBRL_DATA,
            EXC_TLBRS:
            begin
                exc_vector = REFILL_VECTOR;
            end
            EXC_ERET:
            begin
                // return to the last retired pc
                exc_vector = epc;
            end
            default:
            begin
                // all other codes take the general vector
                exc_vector = GENERAL_VECTOR;
            end
        endcase
    end

    // an exception outranks every stall request
    always_comb
    begin
        stall  = STALL_NONE;
        flush  = 1'b0;
        new_pc = '0;
        if (exc_taken)
        begin
            // flush everything and ignore the stalls
            flush  = 1'b1;
            new_pc = exc_vector;
        end
        else if (stallreq_mem)
        begin
            stall = STALL_MEM;
        end
        else if (stallreq_ex)
        begin
            stall = STALL_EX;
        end
        else if (stallreq_id)
        begin
            stall = STALL_ID;
        end
    end

endmodule

`default_nettype wire
